/* dv/tb_aggr.sv */
`timescale 1ns/1ns

module tb_aggr;

  localparam int NUM_CH = aggr_pkg::NUM_CH;
  localparam int DW = aggr_pkg::DATA_W;
  localparam int DEPTH = aggr_pkg::FIFO_DEPTH;
  localparam int RESET_CYCLES = 5;
  localparam int MIX_PER_CH = 40;
  localparam int TOTAL_WORDS = NUM_CH * MIX_PER_CH + 2 * (NUM_CH * DEPTH + aggr_pkg::OUT_CREDITS);
  localparam int MAX_CYCLES = 20 * TOTAL_WORDS + 200;
  localparam int QUIET = 20;
  // Downstream credit behavior
  localparam int CREDIT_HOLD = 0;
  localparam int CREDIT_RANDOM = 1;
  localparam int CREDIT_EVERY = 2;

  logic                      clk = 1'b0;
  logic                      rst;
  logic [NUM_CH-1:0]         in_valid;
  logic [NUM_CH*DW-1:0]      in_data;
  logic                      out_credit;
  logic [NUM_CH-1:0]         credit_return;
  logic                      out_valid;
  logic [DW-1:0]             out_data;
  logic [aggr_pkg::CH_W-1:0] out_chan;

  // Set by the test sequence
  int target [NUM_CH];
  int credit_mode;
  bit push_rand;
  bit rr_on;
  // Producer and downstream side
  int            drv_pushed [NUM_CH];
  int            ret_sent;
  logic [DW-1:0] exp_mem [NUM_CH][128];
  // Seen on the DUT pins
  int                        mon_pushed [NUM_CH];
  int                        got [NUM_CH];
  int                        crets [NUM_CH];
  int                        recv_total;
  int                        ret_seen;
  int                        mon_errors;
  bit                        rr_have;
  logic [aggr_pkg::CH_W-1:0] rr_prev;
  int                        rr_count;
  int                        main_errors;
  int                        tests_run;
  int                        tests_failed;
  int                        cycles;

  aggr_top DUT (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .in_data       (in_data),
    .out_credit    (out_credit),
    .credit_return (credit_return),
    .out_valid     (out_valid),
    .out_data      (out_data),
    .out_chan      (out_chan)
  );

  always #4 clk = ~clk;

  // Producers push only with credit, downstream returns only what it received
  initial begin : drive
    logic [DW-1:0] word;
    in_valid = '0;
    in_data = '0;
    out_credit = 1'b0;
    forever begin
      @(posedge clk);
      for (int ch = 0; ch < NUM_CH; ch++) begin
        if (!rst && drv_pushed[ch] < target[ch] && drv_pushed[ch] - crets[ch] < DEPTH
            && (!push_rand || $urandom % 2 == 0)) begin
          word = DW'($urandom);
          exp_mem[ch][drv_pushed[ch]] = word;
          drv_pushed[ch]++;
          in_valid[ch] <= 1'b1;
          in_data[ch*DW +: DW] <= word;
        end else begin
          in_valid[ch] <= 1'b0;
        end
      end
      if (!rst && credit_mode != CREDIT_HOLD && recv_total > ret_sent
          && (credit_mode == CREDIT_EVERY || $urandom % 3 == 0)) begin
        out_credit <= 1'b1;
        ret_sent++;
      end else begin
        out_credit <= 1'b0;
      end
    end
  end

  task automatic check_word();
    int ch;
    ch = int'(out_chan);
    if (got[ch] >= mon_pushed[ch]) begin
      $display("t=%0t: word on channel %0d that was never pushed", $time, ch);
      mon_errors++;
    end else if (out_data !== exp_mem[ch][got[ch]]) begin
      $display("FAILED t=%0t out_data ch%0d expected %h got %h",
               $time, ch, exp_mem[ch][got[ch]], out_data);
      mon_errors++;
    end
    got[ch]++;
    recv_total++;
    if (recv_total - ret_seen > aggr_pkg::OUT_CREDITS) begin
      $display("t=%0t: more words outstanding than downstream credits granted", $time);
      mon_errors++;
    end
    if (rr_on) begin
      if (rr_have && out_chan != rr_prev + 1'b1) begin
        $display("FAILED t=%0t out_chan expected %0d got %0d", $time, rr_prev + 1'b1, out_chan);
        mon_errors++;
      end
      rr_prev = out_chan;
      rr_have = 1'b1;
      rr_count++;
    end
  endtask

  always @(negedge clk) begin
    if (!rst) begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        if (in_valid[ch]) mon_pushed[ch]++;
        if (credit_return[ch]) crets[ch]++;
      end
      if (out_credit) ret_seen++;
      if (out_valid) check_word();
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Run stopped at the cycle limit of %0d before the tests finished", MAX_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic int err_count();
    return main_errors + mon_errors;
  endfunction

  function automatic int pushed_total();
    int sum;
    sum = 0;
    for (int ch = 0; ch < NUM_CH; ch++) sum += mon_pushed[ch];
    return sum;
  endfunction

  function automatic bit targets_met();
    for (int ch = 0; ch < NUM_CH; ch++) begin
      if (mon_pushed[ch] != target[ch]) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic check_idle();
    if (out_valid !== 1'b0) begin
      $display("FAILED t=%0t out_valid expected 0 got %b", $time, out_valid);
      main_errors++;
    end
    if (credit_return !== '0) begin
      $display("FAILED t=%0t credit_return expected 0 got %b", $time, credit_return);
      main_errors++;
    end
    if (DUT.grant !== '0) begin
      $display("FAILED t=%0t grant expected 0 got %b", $time, DUT.grant);
      main_errors++;
    end
  endtask

  task automatic wait_drained();
    while (!targets_met() || recv_total != pushed_total() || ret_seen != recv_total) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
  endtask

  // Leaves every FIFO full and the egress credit count at zero
  task automatic fill_withheld();
    credit_mode <= CREDIT_HOLD;
    push_rand <= 1'b0;
    for (int ch = 0; ch < NUM_CH; ch++) target[ch] <= target[ch] + DEPTH;
    @(posedge clk);
    while (!targets_met()) @(posedge clk);
    repeat (QUIET) @(posedge clk);
    // Refill the words that left before the credits ran out
    for (int ch = 0; ch < NUM_CH; ch++) target[ch] <= crets[ch] + DEPTH;
    @(posedge clk);
    while (!targets_met()) @(posedge clk);
    repeat (QUIET) @(posedge clk);
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (err_count() != errs_before) begin
      tests_failed++;
      $display("test %-12s FAIL", name);
    end else begin
      $display("test %-12s pass", name);
    end
  endtask

  initial begin : main_seq
    int errs;
    int base;
    rst = 1'b1;
    credit_mode = CREDIT_RANDOM;
    push_rand = 1'b0;
    rr_on = 1'b0;
    void'($urandom(32'h7821_23d2));

    errs = err_count();
    repeat (RESET_CYCLES - 1) begin
      @(negedge clk);
      check_idle();
    end
    @(posedge clk);
    rst <= 1'b0;
    repeat (10) begin
      @(negedge clk);
      check_idle();
    end
    end_test("reset", errs);

    errs = err_count();
    @(posedge clk);
    push_rand <= 1'b1;
    for (int ch = 0; ch < NUM_CH; ch++) target[ch] <= target[ch] + MIX_PER_CH;
    @(posedge clk);
    wait_drained();
    for (int ch = 0; ch < NUM_CH; ch++) begin
      if (got[ch] != mon_pushed[ch]) begin
        $display("FAILED t=%0t words_out ch%0d expected %0d got %0d",
                 $time, ch, mon_pushed[ch], got[ch]);
        main_errors++;
      end
    end
    end_test("order", errs);

    errs = err_count();
    for (int ch = 0; ch < NUM_CH; ch++) begin
      if (crets[ch] != mon_pushed[ch]) begin
        $display("FAILED t=%0t credit_return count ch%0d expected %0d got %0d",
                 $time, ch, mon_pushed[ch], crets[ch]);
        main_errors++;
      end
    end
    end_test("in_credits", errs);

    errs = err_count();
    base = recv_total;
    fill_withheld();
    if (recv_total - base != aggr_pkg::OUT_CREDITS) begin
      $display("FAILED t=%0t words sent without credit expected %0d got %0d",
               $time, aggr_pkg::OUT_CREDITS, recv_total - base);
      main_errors++;
    end
    credit_mode <= CREDIT_RANDOM;
    @(posedge clk);
    wait_drained();
    end_test("backpressure", errs);

    errs = err_count();
    fill_withheld();
    rr_on <= 1'b1;
    credit_mode <= CREDIT_EVERY;
    @(posedge clk);
    wait_drained();
    if (rr_count != NUM_CH * DEPTH) begin
      $display("FAILED t=%0t rotation words expected %0d got %0d", $time, NUM_CH * DEPTH, rr_count);
      main_errors++;
    end
    end_test("round_robin", errs);

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count());
    if (err_count() == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* filelist.f */
source/aggr_pkg.sv
source/sync_fifo.sv
source/chan_ingress.sv
source/rr_arbiter.sv
source/egress_credit.sv
source/aggr_top.sv
dv/tb_aggr.sv

/* run.sh */
#!/bin/sh
# Build and run the aggregator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_aggr -f filelist.f

# The log decides the result, also when the simulation stops early
./obj_dir/Vtb_aggr > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: no errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* source/aggr_pkg.sv */
package aggr_pkg;

  // Producer channels and the width of a channel tag
  localparam int NUM_CH = 4;
  localparam int CH_W = $clog2(NUM_CH);

  localparam int DATA_W = 16;

  // Ingress FIFO size, which is also the producer credit count
  localparam int FIFO_DEPTH_BITS = 3;
  localparam int FIFO_DEPTH = 2 ** FIFO_DEPTH_BITS;

  // Downstream credits held by the egress stage after reset
  localparam int OUT_CREDITS = 4;
  localparam int CREDIT_W = 3;

endpackage

/* source/aggr_top.sv */
`timescale 1ns/1ns

module aggr_top (
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic [aggr_pkg::NUM_CH-1:0]                   in_valid,
  input  logic [aggr_pkg::NUM_CH*aggr_pkg::DATA_W-1:0]  in_data,
  input  logic                                          out_credit,
  output logic [aggr_pkg::NUM_CH-1:0]                   credit_return,
  output logic                                          out_valid,
  output logic [aggr_pkg::DATA_W-1:0]                   out_data,
  output logic [aggr_pkg::CH_W-1:0]                     out_chan
);

  logic [aggr_pkg::NUM_CH-1:0]                  req;
  logic [aggr_pkg::NUM_CH-1:0]                  grant;
  logic                                         grant_valid;
  logic [aggr_pkg::CH_W-1:0]                    grant_ch;
  logic                                         send_ok;
  logic [aggr_pkg::NUM_CH*aggr_pkg::DATA_W-1:0] fifo_data;

  // One ingress FIFO per producer, channel 0 in the low bits
  for (genvar gi = 0; gi < aggr_pkg::NUM_CH; gi++) begin : g_ch
    chan_ingress u_ingress (
      .clk           (clk),
      .rst           (rst),
      .push          (in_valid[gi]),
      .push_data     (in_data[gi*aggr_pkg::DATA_W +: aggr_pkg::DATA_W]),
      .pop           (grant[gi]),
      .pop_data      (fifo_data[gi*aggr_pkg::DATA_W +: aggr_pkg::DATA_W]),
      .not_empty     (req[gi]),
      .credit_return (credit_return[gi])
    );
  end

  rr_arbiter u_arb (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .send_ok     (send_ok),
    .grant       (grant),
    .grant_valid (grant_valid),
    .grant_ch    (grant_ch)
  );

  egress_credit u_egress (
    .clk         (clk),
    .rst         (rst),
    .grant_valid (grant_valid),
    .grant_ch    (grant_ch),
    .fifo_data   (fifo_data),
    .out_credit  (out_credit),
    .send_ok     (send_ok),
    .out_valid   (out_valid),
    .out_data    (out_data),
    .out_chan    (out_chan)
  );

endmodule

/* source/chan_ingress.sv */
`timescale 1ns/1ns

module chan_ingress (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        push,
  input  logic [aggr_pkg::DATA_W-1:0] push_data,
  input  logic                        pop,
  output logic [aggr_pkg::DATA_W-1:0] pop_data,
  output logic                        not_empty,
  output logic                        credit_return
);

  logic                              empty;
  logic                              full;
  // Shadow of the credits the producer still holds
  logic [aggr_pkg::FIFO_DEPTH_BITS:0] prod_credits;

  sync_fifo #(
    .WIDTH      (aggr_pkg::DATA_W),
    .DEPTH_BITS (aggr_pkg::FIFO_DEPTH_BITS)
  ) u_fifo (
    .clk   (clk),
    .rst   (rst),
    .we    (push),
    .din   (push_data),
    .re    (pop),
    .dout  (pop_data),
    .empty (empty),
    .full  (full)
  );

  assign not_empty = ~empty;

  // One credit back per word popped
  always_ff @(posedge clk) begin
    if (rst) begin
      credit_return <= 1'b0;
    end else begin
      credit_return <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      prod_credits <= (aggr_pkg::FIFO_DEPTH_BITS + 1)'(aggr_pkg::FIFO_DEPTH);
    end else begin
      case ({push, credit_return})
        2'b10:   prod_credits <= prod_credits - 1'b1;
        2'b01:   prod_credits <= prod_credits + 1'b1;
        default: prod_credits <= prod_credits;
      endcase
    end
  end

  // A producer pushing without credit, or a full FIFO with credits still out
  a_credit_ok: assert property (@(posedge clk) disable iff (rst)
    (push |-> prod_credits != 0) and (full |-> prod_credits == 0))
    else $error("chan_ingress: producer credit violation");

endmodule

/* source/egress_credit.sv */
`timescale 1ns/1ns

module egress_credit (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 grant_valid,
  input  logic [aggr_pkg::CH_W-1:0]            grant_ch,
  input  logic [aggr_pkg::NUM_CH*aggr_pkg::DATA_W-1:0] fifo_data,
  input  logic                                 out_credit,
  output logic                                 send_ok,
  output logic                                 out_valid,
  output logic [aggr_pkg::DATA_W-1:0]          out_data,
  output logic [aggr_pkg::CH_W-1:0]            out_chan
);

  logic [aggr_pkg::CREDIT_W-1:0] credits;
  // Grant delayed to line up with the FIFO read register
  logic                          sel_valid;
  logic [aggr_pkg::CH_W-1:0]     sel_ch;

  assign send_ok = credits != '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= aggr_pkg::CREDIT_W'(aggr_pkg::OUT_CREDITS);
    end else begin
      case ({grant_valid, out_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sel_valid <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      sel_valid <= grant_valid;
      out_valid <= sel_valid;
    end
  end

  always_ff @(posedge clk) begin
    sel_ch   <= grant_ch;
    out_chan <= sel_ch;
    out_data <= fifo_data[sel_ch*aggr_pkg::DATA_W +: aggr_pkg::DATA_W];
  end

  // Downstream returned more than it got, or a grant with no credit left
  a_credit_range: assert property (@(posedge clk) disable iff (rst)
    credits <= aggr_pkg::CREDIT_W'(aggr_pkg::OUT_CREDITS))
    else $error("egress_credit: credit overflow %0d", credits);

  a_no_credit_underflow: assert property (@(posedge clk) disable iff (rst)
    grant_valid |-> credits != '0)
    else $error("egress_credit: grant without credit");

endmodule

/* source/rr_arbiter.sv */
`timescale 1ns/1ns

module rr_arbiter (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [aggr_pkg::NUM_CH-1:0] req,
  input  logic                        send_ok,
  output logic [aggr_pkg::NUM_CH-1:0] grant,
  output logic                        grant_valid,
  output logic [aggr_pkg::CH_W-1:0]   grant_ch
);

  logic [aggr_pkg::CH_W-1:0] last_ch;
  logic [aggr_pkg::CH_W-1:0] cand;

  // Search starts just after the last winner and wraps
  always_comb begin
    grant       = '0;
    grant_valid = 1'b0;
    grant_ch    = '0;
    cand        = last_ch;
    for (int i = 1; i <= aggr_pkg::NUM_CH; i++) begin
      cand = last_ch + i[aggr_pkg::CH_W-1:0];
      if (send_ok && !grant_valid && req[cand]) begin
        grant_valid = 1'b1;
        grant_ch    = cand;
        grant[cand] = 1'b1;
      end
    end
  end

  // Channel 0 goes first after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      last_ch <= {aggr_pkg::CH_W{1'b1}};
    end else if (grant_valid) begin
      last_ch <= grant_ch;
    end
  end

  a_grant_legal: assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant) && (send_ok || grant == '0))
    else $error("rr_arbiter: illegal grant %b", grant);

endmodule

/* source/sync_fifo.sv */
`timescale 1ns/1ns

module sync_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH_BITS = 4
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             we,
  input  logic [WIDTH-1:0] din,
  input  logic             re,
  output logic [WIDTH-1:0] dout,
  output logic             empty,
  output logic             full
);

  logic [DEPTH_BITS-1:0] rp;
  logic [DEPTH_BITS-1:0] wp;
  // One extra bit so a full FIFO can be counted
  logic [DEPTH_BITS:0]   count;
  logic [WIDTH-1:0]      mem [0:(1 << DEPTH_BITS)-1];
  logic                  push_ok;
  logic                  pop_ok;

  assign push_ok = we & ~full;
  assign pop_ok  = re & ~empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      rp    <= '0;
      wp    <= '0;
      count <= '0;
      empty <= 1'b1;
      full  <= 1'b0;
    end else begin
      case ({push_ok, pop_ok})
        2'b11: begin
          rp <= rp + 1'b1;
          wp <= wp + 1'b1;
        end
        2'b10: begin
          wp    <= wp + 1'b1;
          count <= count + 1'b1;
          empty <= 1'b0;
          if (count == {1'b0, {DEPTH_BITS{1'b1}}}) begin
            full <= 1'b1;
          end
        end
        2'b01: begin
          rp    <= rp + 1'b1;
          count <= count - 1'b1;
          full  <= 1'b0;
          if (count == {{DEPTH_BITS{1'b0}}, 1'b1}) begin
            empty <= 1'b1;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // Storage and read register
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wp] <= din;
    end
    if (pop_ok) begin
      dout <= mem[rp];
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(we && full))
    else $error("sync_fifo: push while full");

  a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(re && empty))
    else $error("sync_fifo: pop while empty");

endmodule
